// ==== Makefile ====
TOOL      := verilator
TOP       := cpuTb
FILELIST  := src.f
COMMON    := --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)
LINTFLAGS := --lint-only
SIMFLAGS  := --binary -Wno-fatal
OBJDIR    := obj_dir
LOG       := sim.log
PASSMSG   := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINTFLAGS) $(COMMON)

sim:
	$(TOOL) $(SIMFLAGS) $(COMMON) --Mdir $(OBJDIR) -o V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASSMSG)' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== logic/cpuPkg.sv ====
package cpuPkg;

	localparam int wordWidth = 16;		// Data and address width
	localparam int numRegs = 4;
	localparam int addrFieldWidth = 11;	// Immediate address bits in the instruction

	// Opcodes, top two bits of every instruction
	localparam logic [1:0] opAdd = 2'd0;
	localparam logic [1:0] opLd = 2'd1;
	localparam logic [1:0] opSt = 2'd2;
	localparam logic [1:0] opBrz = 2'd3;

	// Register form, used by ADD and the ext=1 forms
	typedef struct packed {
		logic [1:0] opcode;
		logic [1:0] regIn;		// Write-back or store source
		logic [1:0] regOut1;	// First operand, address or branch target
		logic [1:0] regOut2;	// Second operand, register store data
		logic [6:0] unused;
		logic ext;				// Selects addressing form
	} regView_t;

	// Absolute and relative forms, field overlaps regOut1/regOut2
	typedef struct packed {
		logic [1:0] opcode;
		logic [1:0] regIn;
		logic [addrFieldWidth-1:0] addrField;
		logic ext;
	} addrView_t;

	// One word, two decodings
	typedef union packed {
		regView_t regView;
		addrView_t addrView;
	} instrWord;

	typedef enum logic [1:0] {
		pcIncr = 2'd0,		// PC + 1
		pcRel = 2'd1,		// PC + sign-extended field
		pcReg = 2'd2		// Jump to regOut1 value
	} nextPcSel;

	typedef struct packed {
		nextPcSel pcSel;
		logic regDataFromMem;		// Write-back source is load data
		logic regWe;
		logic aluAdd;
		logic memWe;
		logic memRd;
		logic dAddrFromReg;			// Data address from rdA, else addr
		logic storeFromRegIn;		// Store data from rdIn, else rdB
		logic [1:0] regInSel;
		logic [1:0] regOutSel1;
		logic [1:0] regOutSel2;
		logic [wordWidth-1:0] addr;	// Extended address field
	} ctrlBus;

	// Wishbone classic, master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [wordWidth-1:0] adr;
		logic [wordWidth-1:0] datW;
	} wbReq;

	// Slave to master
	typedef struct packed {
		logic ack;
		logic [wordWidth-1:0] datR;
	} wbRsp;

endpackage

// ==== logic/cpuTop.sv ====
module cpuTop (
	input logic clk,
	input logic arstN,

	output cpuPkg::wbReq ibusReq,	// Instruction memory master
	input cpuPkg::wbRsp ibusRsp,
	output cpuPkg::wbReq dbusReq,	// Data memory master
	input cpuPkg::wbRsp dbusRsp
);

	import cpuPkg::*;

	instrWord instr;
	ctrlBus ctrl;
	logic execStrobe;
	logic memStart;
	logic memDone;
	logic needMem;
	logic zFlag;
	logic [wordWidth-1:0] pc;
	logic [wordWidth-1:0] rdA;
	logic [wordWidth-1:0] rdB;
	logic [wordWidth-1:0] rdIn;
	logic [wordWidth-1:0] loadData;

	assign needMem = ctrl.memWe || ctrl.memRd;	// LD or ST goes through the data port

	fetchUnit fetchUnit_inst (
		.clk(clk), .arstN(arstN),
		.ibusReq(ibusReq), .ibusRsp(ibusRsp),
		.pc(pc), .memDone(memDone), .needMem(needMem),
		.instr(instr), .execStrobe(execStrobe), .memStart(memStart)
	);

	decoder decoder_inst (
		.instr(instr), .zFlag(zFlag), .ctrl(ctrl)
	);

	execUnit execUnit_inst (
		.clk(clk), .arstN(arstN),
		.execStrobe(execStrobe), .memDone(memDone),
		.ctrl(ctrl), .loadData(loadData),
		.rdA(rdA), .rdB(rdB), .rdIn(rdIn),
		.zFlag(zFlag), .pc(pc)
	);

	memAccess memAccess_inst (
		.clk(clk), .arstN(arstN), .memStart(memStart),
		.ctrl(ctrl), .rdA(rdA), .rdB(rdB), .rdIn(rdIn),
		.dbusReq(dbusReq), .dbusRsp(dbusRsp),
		.loadData(loadData), .memDone(memDone)
	);

endmodule

// ==== logic/decoder.sv ====
module decoder (
	input cpuPkg::instrWord instr,
	input logic zFlag,			// Branch condition
	output cpuPkg::ctrlBus ctrl
);

	import cpuPkg::*;

	logic [1:0] opcode;
	logic ext;

	// Both views share opcode, regIn and ext
	assign opcode = instr.regView.opcode;
	assign ext = instr.regView.ext;

	always_comb begin
		ctrl = '0;
		ctrl.pcSel = pcIncr;

		// Register selects come straight from the fields, unused ones are harmless
		ctrl.regInSel = instr.regView.regIn;
		ctrl.regOutSel1 = instr.regView.regOut1;
		ctrl.regOutSel2 = instr.regView.regOut2;

		case (opcode)
		opAdd: begin
			ctrl.aluAdd = 1'b1;
			ctrl.regWe = 1'b1;		// Sum into regIn
		end

		opLd: begin
			ctrl.memRd = 1'b1;
			ctrl.regDataFromMem = 1'b1;
			ctrl.regWe = 1'b1;
			if (ext) begin
				ctrl.dAddrFromReg = 1'b1;	// Address held in regOut1
			end else begin
				// Absolute, zero filled
				ctrl.addr = {{(wordWidth - addrFieldWidth){1'b0}}, instr.addrView.addrField};
			end
		end

		opSt: begin
			ctrl.memWe = 1'b1;
			if (ext) begin
				ctrl.dAddrFromReg = 1'b1;	// regOut2 to [regOut1]
			end else begin
				ctrl.storeFromRegIn = 1'b1;	// regIn to absolute address
				ctrl.addr = {{(wordWidth - addrFieldWidth){1'b0}}, instr.addrView.addrField};
			end
		end

		opBrz: begin
			// Falls through as PC + 1 when the flag is clear
			if (zFlag) begin
				if (ext) begin
					ctrl.pcSel = pcReg;
				end else begin
					ctrl.pcSel = pcRel;
					// Sign extend for backward branches
					ctrl.addr = {{(wordWidth - addrFieldWidth){instr.addrView.addrField[addrFieldWidth-1]}},
						instr.addrView.addrField};
				end
			end
		end

		default: begin
			ctrl.pcSel = pcIncr;
		end
		endcase
	end

endmodule

// ==== logic/execUnit.sv ====
module execUnit (
	input logic clk,
	input logic arstN,
	input logic execStrobe,		// One cycle after fetch ack
	input logic memDone,		// Data cycle complete
	input cpuPkg::ctrlBus ctrl,
	input logic [cpuPkg::wordWidth-1:0] loadData,

	output logic [cpuPkg::wordWidth-1:0] rdA,	// regOut1
	output logic [cpuPkg::wordWidth-1:0] rdB,	// regOut2
	output logic [cpuPkg::wordWidth-1:0] rdIn,	// regIn
	output logic zFlag,
	output logic [cpuPkg::wordWidth-1:0] pc
);

	import cpuPkg::*;

	logic [wordWidth-1:0] regFile [numRegs];
	logic [wordWidth-1:0] aluOut;
	logic [wordWidth-1:0] wrData;
	logic [wordWidth-1:0] nextPc;
	logic [wordWidth-1:0] pcPlusOne;
	logic isMemOp;
	logic execWrite;
	logic loadWrite;

	// Three read ports
	assign rdA = regFile[ctrl.regOutSel1];
	assign rdB = regFile[ctrl.regOutSel2];
	assign rdIn = regFile[ctrl.regInSel];

	assign aluOut = ctrl.aluAdd ? (rdA + rdB) : rdA;	// Only add is encoded
	assign wrData = ctrl.regDataFromMem ? loadData : aluOut;

	assign isMemOp = ctrl.memWe || ctrl.memRd;

	// ALU results land at execute, loads once the bus returns
	assign execWrite = execStrobe && ctrl.regWe && !ctrl.regDataFromMem;
	assign loadWrite = memDone && ctrl.regWe && ctrl.regDataFromMem;

	assign pcPlusOne = pc + 1'b1;

	always_comb begin
		case (ctrl.pcSel)
		pcRel: nextPc = pc + ctrl.addr;	// addr already sign extended
		pcReg: nextPc = rdA;
		default: nextPc = pcPlusOne;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regFile[i] <= '0;
			end
		end else if (execWrite || loadWrite) begin
			regFile[ctrl.regInSel] <= wrData;
		end
	end

	// Flag only follows ADD
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			zFlag <= 1'b0;
		end else if (execStrobe && ctrl.aluAdd) begin
			zFlag <= (aluOut == '0);
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;	// First fetch from 0
		end else if (execStrobe && !isMemOp) begin
			pc <= nextPc;	// ADD and BRZ
		end else if (memDone) begin
			pc <= pcPlusOne;	// LD and ST always fall through
		end
	end

endmodule

// ==== logic/fetchUnit.sv ====
module fetchUnit (
	input logic clk,
	input logic arstN,

	output cpuPkg::wbReq ibusReq,	// Instruction fetch port
	input cpuPkg::wbRsp ibusRsp,

	input logic [cpuPkg::wordWidth-1:0] pc,	// Fetch address from execUnit
	input logic memDone,			// Data cycle finished
	input logic needMem,			// Decoded instruction is LD or ST

	output cpuPkg::instrWord instr,
	output logic execStrobe,
	output logic memStart
);

	// Fetch, execute and memory phases run back to back
	typedef enum logic [1:0] {
		sFetch = 2'd0,
		sExec = 2'd1,
		sMem = 2'd2
	} seqState_t;

	seqState_t state;
	logic cycQ;		// Instruction-side cycle in progress

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= sFetch;
			cycQ <= 1'b0;	// Bus idle coming out of reset
		end else begin
			case (state)
			sFetch: begin
				if (!cycQ) begin
					cycQ <= 1'b1;	// First fetch after reset
				end else if (ibusRsp.ack) begin
					cycQ <= 1'b0;	// Single transfer, drop right after ack
					state <= sExec;
				end
			end

			sExec: begin
				if (needMem) begin
					state <= sMem;
				end else begin
					// ADD and BRZ finish here, PC already updated
					state <= sFetch;
					cycQ <= 1'b1;
				end
			end

			sMem: begin
				if (memDone) begin
					state <= sFetch;
					cycQ <= 1'b1;
				end
			end

			default: begin
				state <= sFetch;
				cycQ <= 1'b0;
			end
			endcase
		end
	end

	// Fetched word held for decode through exec and mem
	always_ff @(posedge clk) begin
		if (state == sFetch && cycQ && ibusRsp.ack) begin
			instr <= ibusRsp.datR;
		end
	end

	// Read-only master, address follows PC
	always_comb begin
		ibusReq.cyc = cycQ;
		ibusReq.stb = cycQ;
		ibusReq.we = 1'b0;
		ibusReq.adr = pc;	// PC stays put while the fetch waits
		ibusReq.datW = '0;
	end

	assign execStrobe = (state == sExec);	// Exec state lasts one cycle
	assign memStart = execStrobe && needMem;	// Kick data cycle on the way into mem

endmodule

// ==== logic/memAccess.sv ====
module memAccess (
	input logic clk,
	input logic arstN,
	input logic memStart,		// Pulse from the sequencer
	input cpuPkg::ctrlBus ctrl,
	input logic [cpuPkg::wordWidth-1:0] rdA,
	input logic [cpuPkg::wordWidth-1:0] rdB,
	input logic [cpuPkg::wordWidth-1:0] rdIn,

	output cpuPkg::wbReq dbusReq,	// Data port
	input cpuPkg::wbRsp dbusRsp,

	output logic [cpuPkg::wordWidth-1:0] loadData,
	output logic memDone
);

	import cpuPkg::*;

	logic [wordWidth-1:0] dAddr;
	logic [wordWidth-1:0] stData;
	logic [wordWidth-1:0] adrQ;
	logic [wordWidth-1:0] datQ;
	logic cycQ;
	logic weQ;
	logic doneQ;

	// Register form takes the address from regOut1
	assign dAddr = ctrl.dAddrFromReg ? rdA : ctrl.addr;
	assign stData = ctrl.storeFromRegIn ? rdIn : rdB;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			cycQ <= 1'b0;
			weQ <= 1'b0;
			doneQ <= 1'b0;
		end else begin
			doneQ <= 1'b0;
			if (memStart) begin
				cycQ <= 1'b1;
				weQ <= ctrl.memWe;
			end else if (cycQ && dbusRsp.ack) begin
				cycQ <= 1'b0;	// Drop in the cycle after ack
				doneQ <= 1'b1;	// Data is in loadData by now
			end
		end
	end

	// Address and store data frozen for the whole transfer
	always_ff @(posedge clk) begin
		if (memStart) begin
			adrQ <= dAddr;
			datQ <= stData;
		end
	end

	always_ff @(posedge clk) begin
		if (cycQ && dbusRsp.ack && !weQ) begin
			loadData <= dbusRsp.datR;
		end
	end

	always_comb begin
		dbusReq.cyc = cycQ;
		dbusReq.stb = cycQ;
		dbusReq.we = weQ;
		dbusReq.adr = adrQ;
		dbusReq.datW = datQ;
	end

	assign memDone = doneQ;

endmodule

// ==== src.f ====
logic/cpuPkg.sv
logic/fetchUnit.sv
logic/decoder.sv
logic/execUnit.sv
logic/memAccess.sv
logic/cpuTop.sv
testbench/cpuChk.sv
testbench/cpuTb.sv

// ==== testbench/cpuChk.sv ====
module cpuChk (
	input logic clk,
	input logic arstN,
	input cpuPkg::wbReq ibusReq,
	input cpuPkg::wbRsp ibusRsp,
	input cpuPkg::wbReq dbusReq,
	input cpuPkg::wbRsp dbusRsp
);

	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0;	// Bus protocol violations so far

	// Strobe only inside a cycle
	ibusStbCyc: assert property (@(posedge clk) disable iff (!arstN)
		ibusReq.stb |-> ibusReq.cyc)
		else begin
			$error("ibus stb without cyc");
			failCount++;
		end
	dbusStbCyc: assert property (@(posedge clk) disable iff (!arstN)
		dbusReq.stb |-> dbusReq.cyc)
		else begin
			$error("dbus stb without cyc");
			failCount++;
		end

	// Request frozen until the slave answers
	ibusHold: assert property (@(posedge clk) disable iff (!arstN)
		ibusReq.stb && !ibusRsp.ack |=>
		ibusReq.stb && $stable({ibusReq.adr, ibusReq.we, ibusReq.datW}))
		else begin
			$error("ibus request changed before ack");
			failCount++;
		end
	dbusHold: assert property (@(posedge clk) disable iff (!arstN)
		dbusReq.stb && !dbusRsp.ack |=>
		dbusReq.stb && $stable({dbusReq.adr, dbusReq.we, dbusReq.datW}))
		else begin
			$error("dbus request changed before ack");
			failCount++;
		end

	// Single transfer with strobe gone the cycle after ack
	ibusDrop: assert property (@(posedge clk) disable iff (!arstN)
		ibusReq.stb && ibusRsp.ack |=> !ibusReq.stb)
		else begin
			$error("ibus stb held after ack");
			failCount++;
		end
	dbusDrop: assert property (@(posedge clk) disable iff (!arstN)
		dbusReq.stb && dbusRsp.ack |=> !dbusReq.stb)
		else begin
			$error("dbus stb held after ack");
			failCount++;
		end

	busExcl: assert property (@(posedge clk) disable iff (!arstN)
		!(ibusReq.cyc && dbusReq.cyc))
		else begin
			$error("ibus and dbus active together");
			failCount++;
		end

endmodule

bind cpuTop cpuChk cpuChk_inst (
	.clk(clk), .arstN(arstN),
	.ibusReq(ibusReq), .ibusRsp(ibusRsp),
	.dbusReq(dbusReq), .dbusRsp(dbusRsp)
);

// ==== testbench/cpuTb.sv ====
module cpuTb;

	timeunit 1ns;
	timeprecision 100ps;

	import cpuPkg::*;

	localparam int stimDepth = 256;
	localparam int maxItems = 64;

	logic clk = 1'b0;
	logic arstN = 1'b0;
	wbReq ibusReq;
	wbReq dbusReq;
	wbRsp ibusRsp = '0;
	wbRsp dbusRsp = '0;

	logic [15:0] stim [stimDepth];
	logic [15:0] imem [65536];	// Full 16-bit address space
	logic [15:0] dmem [65536];
	logic [15:0] expFetch [maxItems];
	logic [15:0] expStAdr [maxItems];
	logic [15:0] expStDat [maxItems];
	logic [15:0] lfsr = 16'd13414;
	logic [15:0] lastFetch;
	int stimPtr;
	int fetchLen;
	int storeLen;
	int fetchIdx;
	int storeIdx;
	int testErrs;
	int totalErrs;
	int checks;
	int passed;
	int failed;
	int cycles;
	int cycleLimit;
	int ibusWait;
	int dbusWait;
	bit ibusBusy;
	bit dbusBusy;
	bit tracing;
	bit loopSeen;

	cpuTop cpuTop_inst (
		.clk(clk), .arstN(arstN),
		.ibusReq(ibusReq), .ibusRsp(ibusRsp),
		.dbusReq(dbusReq), .dbusRsp(dbusRsp)
	);

	always #10 clk = ~clk;	// 20 ns period

	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// Two bits per transfer give 0 to 3 wait cycles
	task automatic drawDelay(output int d);
		d = 0;
		repeat (2) begin
			lfsr = lfsrNext(lfsr);
			d = (d << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic traceFetch(input logic [15:0] adr, input logic we);
		if (fetchIdx >= fetchLen) begin
			$display("fetch from %h runs past the expected trace", adr);
			testErrs++;
			loopSeen = 1'b1;	// Stop the test rather than wait for timeout
		end else begin
			checks += 2;
			assert (adr == expFetch[fetchIdx]) else begin
				$display("CHECK FAILED ibusReq.adr fetch %0d: got %h, expected %h",
					fetchIdx, adr, expFetch[fetchIdx]);
				testErrs++;
			end
			assert (!we) else begin
				$display("CHECK FAILED ibusReq.we fetch %0d: got %h, expected 0",
					fetchIdx, we);
				testErrs++;
			end
			fetchIdx++;
		end
		if (fetchIdx > 1 && adr == lastFetch) begin
			loopSeen = 1'b1;	// Branch to itself ends the program
		end
		lastFetch = adr;
	endtask

	task automatic traceStore(input logic [15:0] adr, input logic [15:0] dat);
		if (storeIdx >= storeLen) begin
			$display("unexpected store of %h to address %h", dat, adr);
			testErrs++;
		end else begin
			checks += 2;
			assert (adr == expStAdr[storeIdx]) else begin
				$display("CHECK FAILED dbusReq.adr store %0d: got %h, expected %h",
					storeIdx, adr, expStAdr[storeIdx]);
				testErrs++;
			end
			assert (dat == expStDat[storeIdx]) else begin
				$display("CHECK FAILED dbusReq.datW store %0d: got %h, expected %h",
					storeIdx, dat, expStDat[storeIdx]);
				testErrs++;
			end
			storeIdx++;
		end
	endtask

	// Instruction memory slave
	always @(posedge clk) begin
		#1;
		if (ibusRsp.ack || !ibusReq.stb) begin
			ibusRsp.ack = 1'b0;	// Transfer taken or aborted by reset
			ibusBusy = 1'b0;
		end else begin
			if (!ibusBusy) begin
				ibusBusy = 1'b1;
				drawDelay(ibusWait);
				if (tracing) begin
					traceFetch(ibusReq.adr, ibusReq.we);
				end
			end
			if (ibusWait == 0) begin
				ibusRsp.ack = 1'b1;
				ibusRsp.datR = imem[ibusReq.adr];
			end else begin
				ibusWait--;
			end
		end
	end

	// Data memory slave with writes landing at ack
	always @(posedge clk) begin
		#1;
		if (dbusRsp.ack || !dbusReq.stb) begin
			dbusRsp.ack = 1'b0;
			dbusBusy = 1'b0;
		end else begin
			if (!dbusBusy) begin
				dbusBusy = 1'b1;
				drawDelay(dbusWait);
				if (tracing && dbusReq.we) begin
					traceStore(dbusReq.adr, dbusReq.datW);
				end
			end
			if (dbusWait == 0) begin
				dbusRsp.ack = 1'b1;
				dbusRsp.datR = dmem[dbusReq.adr];
				if (dbusReq.we) begin
					dmem[dbusReq.adr] = dbusReq.datW;
				end
			end else begin
				dbusWait--;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycleLimit > 0 && cycles > cycleLimit) begin
			$display("timeout after %0d cycles, program never reached its end loop", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic runTest(input int num);
		int progLen;
		int dataLen;
		@(posedge clk);
		#1;
		arstN = 1'b0;
		for (int i = 0; i < 65536; i++) begin
			imem[i] = ~16'(i);	// Fill outside the program
			dmem[i] = 16'(i) ^ 16'h5A5A;
		end
		progLen = int'(stim[stimPtr]);
		dataLen = int'(stim[stimPtr+1]);
		fetchLen = int'(stim[stimPtr+2]);
		storeLen = int'(stim[stimPtr+3]);
		stimPtr += 4;
		for (int i = 0; i < progLen; i++) begin
			imem[i] = stim[stimPtr+i];
		end
		stimPtr += progLen;
		for (int i = 0; i < dataLen; i++) begin
			dmem[stim[stimPtr+2*i]] = stim[stimPtr+2*i+1];	// Address then value
		end
		stimPtr += 2 * dataLen;
		for (int i = 0; i < fetchLen; i++) begin
			expFetch[i] = stim[stimPtr+i];
		end
		stimPtr += fetchLen;
		for (int i = 0; i < storeLen; i++) begin
			expStAdr[i] = stim[stimPtr+2*i];
			expStDat[i] = stim[stimPtr+2*i+1];
		end
		stimPtr += 2 * storeLen;
		fetchIdx = 0;
		storeIdx = 0;
		testErrs = 0;
		loopSeen = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		checks++;
		assert (!ibusReq.cyc && !ibusReq.stb && !dbusReq.cyc && !dbusReq.stb) else begin
			$display("CHECK FAILED ibusReq.cyc/stb %h/%h dbusReq.cyc/stb %h/%h, expected 0",
				ibusReq.cyc, ibusReq.stb, dbusReq.cyc, dbusReq.stb);
			testErrs++;
		end
		tracing = 1'b1;
		arstN = 1'b1;
		wait (loopSeen);
		tracing = 1'b0;
		checks++;
		assert (fetchIdx == fetchLen && storeIdx == storeLen) else begin
			$display("test %0d saw %0d of %0d fetches and %0d of %0d stores",
				num, fetchIdx, fetchLen, storeIdx, storeLen);
			testErrs++;
		end
		totalErrs += testErrs;
		if (testErrs == 0) begin
			passed++;
		end else begin
			failed++;
		end
		$display("test %0d %s: %0d fetches, %0d stores, %0d errors",
			num, (testErrs == 0) ? "ok" : "bad", fetchIdx, storeIdx, testErrs);
	endtask

	initial begin
		int p;
		$readmemh("testbench/progStim.txt", stim);
		p = 1;
		cycleLimit = 200;	// Margin on top of the per-fetch budget
		for (int t = 0; t < int'(stim[0]); t++) begin
			cycleLimit += 40 * int'(stim[p+2]) + 10;
			p += 4 + int'(stim[p]) + 2 * int'(stim[p+1]) + int'(stim[p+2])
				+ 2 * int'(stim[p+3]);
		end
		stimPtr = 1;
		for (int t = 0; t < int'(stim[0]); t++) begin
			runTest(t);
		end
		$display("summary: %0d tests passed, %0d failed, %0d checks, %0d errors, %0d bus errors",
			passed, failed, checks, totalErrs, cpuTop_inst.cpuChk_inst.failCount);
		if (failed == 0 && totalErrs == 0 && cpuTop_inst.cpuChk_inst.failCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== testbench/progStim.txt ====
// Word 0 is the test count. Each test: progLen dataLen fetchLen storeLen, program words,
// data memory (addr value) pairs, expected fetch addresses, expected stores (addr data)
0003
// Absolute loads, adds with a zero sum, absolute and register stores
000B 0005 000C 0003
5020 6022 3600 B060 6026 3600 B062 4024 6001 8201 C000
0010 1234  0011 0FF0  0012 0020  0013 EDCC  0020 BEEF
0000 0001 0002 0003 0004 0005 0006 0007 0008 0009 000A 000A
0030 2224  0031 0000  0020 BEEF
// Branches not taken with the flag clear, then forward, backward and register
000F 0003 000F 0002
5000 6002 C00A C401 0500 C006 3600 C008
8080 9082 C001 4004 CFFA 8084 C000
0000 0001  0001 FFFF  0002 000D
0000 0001 0002 0003 0004 0005 0006 0007 000B 000C 0009 000A 000D 000E 000E
0041 0001  0042 000D
// Doubling up to overflow, register stores through a pointer
0007 0002 0008 0002
500A 1500 600C 8901 1500 8901 C000
0005 4000  0006 0050
0000 0001 0002 0003 0004 0005 0006 0006
0050 8000  0050 0000
